// ==== filelist.f ====
+incdir+verification
source/wb_ctrl_pkg.sv
source/wb_insn_check.sv
source/fencei_flush_ctrl.sv
source/wb_event_arbiter.sv
source/wb_ctrl_top.sv
verification/wb_ctrl_tb.sv

// ==== verification/wb_ctrl_model.svh ====
// Writeback controller reference model
// Cycle model of the fence.i handshake and the event priority, the queue of
// expected events and the compare tasks of the testbench

`ifndef WB_CTRL_MODEL_SVH
`define WB_CTRL_MODEL_SVH

// Handshake steps as the model follows them
typedef enum int {
  MF_IDLE,
  MF_WAIT_READY,
  MF_REQ,
  MF_DONE
} model_flush_e;

model_flush_e model_flush;
// High in the cycle after an interrupt was taken
logic         model_irq_ack;
wb_event_t    exp_events[$];

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic report_error(input string what);
  $display("Error at %0t ns: %s", $time, what);
  $display("TEST FAILED");
  $fatal(1, "Stopped at the first error");
endtask

task automatic check_event(input wb_event_t got, input wb_event_t exp);
  if (got !== exp) begin
    report_error($sformatf("event_o kind %0d cause %0d, expected kind %0d cause %0d",
                           got.kind, got.cause, exp.kind, exp.cause));
  end
endtask

task automatic check_flush_req(input logic got, input logic exp);
  if (got !== exp) begin
    report_error($sformatf("fencei_flush_req_o is %b, expected %b", got, exp));
  end
endtask

task automatic check_ready(input logic got, input logic exp);
  if (got !== exp) begin
    report_error($sformatf("wb_ready_o is %b, expected %b", got, exp));
  end
endtask

task automatic check_irq_ack(input logic got, input logic exp);
  if (got !== exp) begin
    report_error($sformatf("irq_ack_o is %b, expected %b", got, exp));
  end
endtask

//////////////////////////////
// Rules
//////////////////////////////

// mret needs machine mode, WFI traps from user mode when tw is set
function automatic verdict_e expected_verdict(input wb_opcode_e op, input priv_lvl_e priv,
                                              input logic tw);
  verdict_e v;
  v = CLS_RETIRE;
  if (op == OP_MRET) begin
    if (priv == PRIV_M) begin
      v = CLS_MRET;
    end else begin
      v = CLS_ILLEGAL;
    end
  end else if ((op == OP_WFI) && (priv == PRIV_U) && tw) begin
    v = CLS_ILLEGAL;
  end
  return v;
endfunction

// Decides one cycle from the inputs seen mid-cycle, queues the event that
// shows up after the next edge and advances the handshake step
// The cycle after an ack is blanked for interrupts, the pending line of the
// interrupt controller only clears once it sees the ack
task automatic predict_cycle(input wb_instr_t instr, input priv_lvl_e priv, input logic tw,
                             input int outstanding, input logic irq_pending,
                             input logic [CAUSE_W-1:0] irq_id, input logic buf_empty,
                             input logic ack, output logic ready);
  logic      is_lsu;
  logic      is_fencei;
  logic      busy;
  wb_event_t ev;
  is_lsu    = instr.valid && (instr.opcode == OP_LSU);
  is_fencei = instr.valid && (instr.opcode == OP_FENCEI);
  busy      = (model_flush == MF_WAIT_READY) || (model_flush == MF_REQ) ||
              ((model_flush == MF_IDLE) && is_fencei);
  ev        = '0;
  ready     = 1'b0;
  if (model_flush == MF_DONE) begin
    ev.valid = 1'b1;
    ev.kind  = EV_FENCEI;
    ready    = 1'b1;
  end else if (irq_pending && !is_lsu && (outstanding == 0) && !busy && !model_irq_ack) begin
    ev.valid = 1'b1;
    ev.kind  = EV_INTERRUPT;
    ev.cause = irq_id;
    ready    = instr.valid;
  end else if (instr.valid && !busy) begin
    ev.valid = 1'b1;
    ready    = 1'b1;
    case (expected_verdict(instr.opcode, priv, tw))
      CLS_ILLEGAL: begin
        ev.kind  = EV_EXCEPTION;
        ev.cause = EXC_ILLEGAL_INSN;
      end
      CLS_MRET: ev.kind = EV_MRET;
      default:  ev.kind = EV_RETIRE;
    endcase
  end
  model_irq_ack = ev.valid && (ev.kind == EV_INTERRUPT);
  case (model_flush)
    MF_IDLE: begin
      if (is_fencei) begin
        model_flush = buf_empty ? MF_REQ : MF_WAIT_READY;
      end
    end
    MF_WAIT_READY: model_flush = buf_empty ? MF_REQ : MF_WAIT_READY;
    MF_REQ:        model_flush = ack ? MF_DONE : MF_REQ;
    default:       model_flush = MF_IDLE;
  endcase
  if (ev.valid) begin
    exp_events.push_back(ev);
  end
endtask

`endif

// ==== verification/wb_ctrl_tb.sv ====
// Writeback controller testbench
// Seeded random instructions, privilege levels, LSU counts and interrupts,
// a fence.i flush responder, and a reference model that checks every event

`timescale 1ns/100ps

module wb_ctrl_tb import wb_ctrl_pkg::*; ();

  localparam int unsigned OUTSTANDING_W = 2;
  localparam int unsigned N_ITEMS       = 600;
  // Generous bound, a fence.i with slow drain and ack takes about 10 cycles
  localparam int unsigned CYCLE_LIMIT   = 20 * N_ITEMS + 200;

  logic                     clk;
  logic                     rst_n;
  wb_instr_t                wb_instr;
  priv_lvl_e                priv_lvl;
  logic                     mstatus_tw;
  logic [OUTSTANDING_W-1:0] lsu_outstanding;
  logic                     irq_pending;
  logic [CAUSE_W-1:0]       irq_id;
  logic                     fencei_ready;
  logic                     fencei_ack;
  logic                     wb_ready;
  logic                     flush_req;
  wb_event_t                dut_event;
  logic                     irq_ack;

  // Mid-cycle view of the handshakes for the edge driven processes
  logic accepted;
  logic req_seen;
  logic stim_done;
  int   items_left;
  int   ack_delay;
  int   cycles;
  int   missing_kind;
  int   kind_seen[5] = '{default: 0};

  `include "wb_ctrl_model.svh"

  initial clk = 1'b0;
  always #5 clk = ~clk;

  wb_ctrl_top #(
    .OUTSTANDING_W (OUTSTANDING_W)
  ) u_dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .wb_instr_i         (wb_instr),
    .priv_lvl_i         (priv_lvl),
    .mstatus_tw_i       (mstatus_tw),
    .lsu_outstanding_i  (lsu_outstanding),
    .irq_pending_i      (irq_pending),
    .irq_id_i           (irq_id),
    .fencei_ready_i     (fencei_ready),
    .fencei_flush_ack_i (fencei_ack),
    .wb_ready_o         (wb_ready),
    .fencei_flush_req_o (flush_req),
    .event_o            (dut_event),
    .irq_ack_o          (irq_ack)
  );

  //////////////////////////////
  // Reset, drain and verdict
  //////////////////////////////

  initial begin
    void'($urandom(32'h950c));
    rst_n           = 1'b0;
    wb_instr        = '0;
    priv_lvl        = PRIV_M;
    mstatus_tw      = 1'b0;
    lsu_outstanding = '0;
    irq_pending     = 1'b0;
    irq_id          = '0;
    fencei_ready    = 1'b0;
    fencei_ack      = 1'b0;
    accepted        = 1'b0;
    req_seen        = 1'b0;
    stim_done       = 1'b0;
    items_left      = N_ITEMS;
    ack_delay       = -1;
    cycles          = 0;
    missing_kind    = -1;
    model_flush     = MF_IDLE;
    model_irq_ack   = 1'b0;
    // Outputs must be quiet while reset is held
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_flush_req(flush_req, 1'b0);
    check_irq_ack(irq_ack, 1'b0);
    check_ready(wb_ready, 1'b0);
    check_event(dut_event, '0);
    @(posedge clk);
    rst_n <= 1'b1;
    wait (stim_done);
    repeat (5) @(posedge clk);
    // First event kind that never showed up, if any
    for (int k = 0; k < 5; k++) begin
      if ((kind_seen[k] == 0) && (missing_kind < 0)) begin
        missing_kind = k;
      end
    end
    if (exp_events.size() != 0) begin
      report_error("expected events never appeared on event_o");
    end else if (missing_kind >= 0) begin
      report_error($sformatf("random stimulus produced no event of kind %0d", missing_kind));
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  always @(posedge clk) begin
    wb_instr_t next_instr;
    if (rst_n && !stim_done) begin
      next_instr = wb_instr;
      // A killed instruction leaves writeback just like a retired one
      if (!wb_instr.valid || accepted) begin
        if (items_left == 0) begin
          next_instr = '0;
          stim_done  = 1'b1;
        end else if (($urandom % 4) == 0) begin
          next_instr = '0;
        end else begin
          next_instr.valid  = 1'b1;
          next_instr.opcode = wb_opcode_e'($urandom % 6);
          items_left--;
          priv_lvl   <= (($urandom % 2) == 1) ? PRIV_M : PRIV_U;
          mstatus_tw <= (($urandom % 2) == 1);
        end
      end
      wb_instr <= next_instr;
      if (stim_done) begin
        irq_pending     <= 1'b0;
        lsu_outstanding <= '0;
      end else begin
        irq_pending     <= (($urandom % 6) == 0);
        irq_id          <= CAUSE_W'($urandom);
        lsu_outstanding <= (($urandom % 3) == 0) ? OUTSTANDING_W'($urandom) : '0;
      end
      // Write buffer drains at a random time and stays empty under a fence.i
      if (next_instr.valid && (next_instr.opcode == OP_FENCEI)) begin
        if (!fencei_ready) begin
          fencei_ready <= (($urandom % 3) == 0);
        end
      end else begin
        fencei_ready <= (($urandom % 2) == 1);
      end
    end
  end

  // Flush responder, acks a seen req after 0 to 5 cycles for one cycle
  always @(posedge clk) begin
    if (rst_n) begin
      if (fencei_ack) begin
        fencei_ack <= 1'b0;
      end else if (req_seen) begin
        if (ack_delay < 0) begin
          ack_delay = $urandom % 6;
        end
        if (ack_delay == 0) begin
          fencei_ack <= 1'b1;
          ack_delay = -1;
        end else begin
          ack_delay--;
        end
      end
    end
  end

  //////////////////////////////
  // Checking
  //////////////////////////////

  // Registered outputs first, then the decision of the current cycle
  always @(negedge clk) begin
    wb_event_t exp_ev;
    logic      exp_ready;
    if (rst_n) begin
      req_seen = flush_req;
      check_irq_ack(irq_ack, model_irq_ack);
      check_flush_req(flush_req, model_flush == MF_REQ);
      if (dut_event.valid) begin
        if (exp_events.size() == 0) begin
          report_error("event_o valid while no event was expected");
        end
        exp_ev = exp_events.pop_front();
        check_event(dut_event, exp_ev);
        kind_seen[int'(exp_ev.kind)]++;
      end else if (exp_events.size() != 0) begin
        report_error("an expected event is missing on event_o");
      end
      predict_cycle(wb_instr, priv_lvl, mstatus_tw, int'(lsu_outstanding), irq_pending,
                    irq_id, fencei_ready, fencei_ack, exp_ready);
      check_ready(wb_ready, exp_ready);
      accepted = exp_ready;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run hung, not finished after %0d clock cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "Timeout");
    end
  end

endmodule

// ==== source/wb_ctrl_top.sv ====
// Writeback-stage controller
// Instruction checker and fence.i flush controller run side by side and
// the event arbiter combines their results into one registered event

`timescale 1ns/100ps

module wb_ctrl_top import wb_ctrl_pkg::*; #(
  parameter int unsigned OUTSTANDING_W = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  wb_instr_t                wb_instr_i,
  input  priv_lvl_e                priv_lvl_i,
  input  logic                     mstatus_tw_i,
  input  logic [OUTSTANDING_W-1:0] lsu_outstanding_i,
  input  logic                     irq_pending_i,
  input  logic [CAUSE_W-1:0]       irq_id_i,
  input  logic                     fencei_ready_i,
  input  logic                     fencei_flush_ack_i,
  output logic                     wb_ready_o,
  output logic                     fencei_flush_req_o,
  output wb_event_t                event_o,
  output logic                     irq_ack_o
);

  // Verdict and LSU/fence.i flags of the writeback instruction
  insn_class_t    insn_class;
  // Flush progress seen by the arbiter
  fencei_status_t fencei_status;

  wb_insn_check u_insn_check (
    .wb_instr_i   (wb_instr_i),
    .priv_lvl_i   (priv_lvl_i),
    .mstatus_tw_i (mstatus_tw_i),
    .insn_class_o (insn_class)
  );

  fencei_flush_ctrl u_fencei_flush (
    .clk                (clk),
    .rst_n              (rst_n),
    .insn_class_i       (insn_class),
    .fencei_ready_i     (fencei_ready_i),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .fencei_flush_req_o (fencei_flush_req_o),
    .fencei_status_o    (fencei_status)
  );

  wb_event_arbiter #(
    .OUTSTANDING_W (OUTSTANDING_W)
  ) u_event_arbiter (
    .clk               (clk),
    .rst_n             (rst_n),
    .wb_instr_i        (wb_instr_i),
    .insn_class_i      (insn_class),
    .fencei_status_i   (fencei_status),
    .lsu_outstanding_i (lsu_outstanding_i),
    .irq_pending_i     (irq_pending_i),
    .irq_id_i          (irq_id_i),
    .wb_ready_o        (wb_ready_o),
    .event_o           (event_o),
    .irq_ack_o         (irq_ack_o)
  );

endmodule

// ==== source/wb_event_arbiter.sv ====
// Writeback event arbiter
// Combines the instruction verdict, the fence.i flush status and pending
// interrupts into one decision per cycle, holds the writeback slot while a
// flush runs, and registers the resulting event and interrupt ack

`timescale 1ns/100ps

module wb_event_arbiter import wb_ctrl_pkg::*; #(
  parameter int unsigned OUTSTANDING_W = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  wb_instr_t                wb_instr_i,
  input  insn_class_t              insn_class_i,
  input  fencei_status_t           fencei_status_i,
  input  logic [OUTSTANDING_W-1:0] lsu_outstanding_i,
  input  logic                     irq_pending_i,
  input  logic [CAUSE_W-1:0]       irq_id_i,
  output logic                     wb_ready_o,
  output wb_event_t                event_o,
  output logic                     irq_ack_o
);

  logic      irq_allowed;
  logic      irq_take;
  logic      irq_ack_d;
  logic      irq_ack_q;
  wb_event_t event_d;
  wb_event_t event_q;

  //////////////////////////////
  // Interrupt gating
  //////////////////////////////

  // A load/store in writeback or on the bus cannot be undone, so an
  // interrupt has to wait until the LSU is quiet
  // A running fence.i flush is not interruptible either
  // The cycle right after an ack is blanked as well, since the pending
  // line from the interrupt controller only clears once the ack is seen
  assign irq_allowed = !insn_class_i.lsu &&
                       (lsu_outstanding_i == '0) &&
                       !fencei_status_i.busy &&
                       !irq_ack_q;

  assign irq_take = irq_pending_i && irq_allowed;

  //////////////////////////////
  // Decision
  //////////////////////////////

  always_comb begin
    event_d    = '0;
    event_d.kind = EV_RETIRE;
    irq_ack_d  = 1'b0;
    wb_ready_o = 1'b0;

    if (fencei_status_i.done) begin
      // Flush finished, the fence.i leaves writeback now
      event_d.valid = 1'b1;
      event_d.kind  = EV_FENCEI;
      wb_ready_o    = 1'b1;
    end else if (irq_take) begin
      // The interrupt kills whatever sits in writeback
      // With an empty slot there is nothing to consume
      event_d.valid = 1'b1;
      event_d.kind  = EV_INTERRUPT;
      event_d.cause = irq_id_i;
      irq_ack_d     = 1'b1;
      wb_ready_o    = wb_instr_i.valid;
    end else if (wb_instr_i.valid && !fencei_status_i.busy) begin
      event_d.valid = 1'b1;
      wb_ready_o    = 1'b1;
      unique case (insn_class_i.verdict)
        CLS_ILLEGAL: begin
          event_d.kind  = EV_EXCEPTION;
          event_d.cause = EXC_ILLEGAL_INSN;
        end
        CLS_MRET: begin
          // Privilege restore by mret happens elsewhere
          event_d.kind = EV_MRET;
        end
        default: begin
          event_d.kind = EV_RETIRE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Registered outputs
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      event_q   <= '0;
      irq_ack_q <= 1'b0;
    end else begin
      event_q   <= event_d;
      irq_ack_q <= irq_ack_d;
    end
  end

  assign event_o   = event_q;
  assign irq_ack_o = irq_ack_q;

  //////////////////////////////
  // Interrupt checks
  //////////////////////////////

  // Each taken interrupt is acknowledged exactly once
  a_irq_ack_single_cycle :
    assert property (@(posedge clk) disable iff (!rst_n)
                     irq_ack_o |=> !irq_ack_o)
      else $error("irq_ack held for more than one cycle");

  // The ack is registered, so the LSU count is checked in the deciding cycle
  a_irq_ack_no_outstanding :
    assert property (@(posedge clk) disable iff (!rst_n)
                     irq_ack_o |-> $past(lsu_outstanding_i == '0))
      else $error("Interrupt taken with load/store transactions outstanding");

  // A load/store in writeback never gets killed by an interrupt
  a_no_irq_over_lsu :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (wb_instr_i.valid && insn_class_i.lsu) |=>
                     !(event_o.valid && (event_o.kind == EV_INTERRUPT)))
      else $error("Interrupt event after a load/store in writeback");

endmodule

// ==== source/fencei_flush_ctrl.sv ====
// Fence.i flush controller
// Runs the req/ack flush handshake for a fence.i in writeback once the
// write buffer is empty, and reports busy and done to the event arbiter

`timescale 1ns/100ps

module fencei_flush_ctrl import wb_ctrl_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  insn_class_t    insn_class_i,
  input  logic           fencei_ready_i,
  input  logic           fencei_flush_ack_i,
  output logic           fencei_flush_req_o,
  output fencei_status_t fencei_status_o
);

  typedef enum logic [1:0] {
    FL_IDLE       = 2'd0,
    FL_WAIT_READY = 2'd1,
    FL_REQ        = 2'd2,
    FL_DONE       = 2'd3
  } fl_state_e;

  fl_state_e state_q;
  fl_state_e state_d;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;

    unique case (state_q)
      FL_IDLE: begin
        // A valid fence.i starts the flush at once if the write buffer
        // is already empty, otherwise it waits for it to drain
        if (insn_class_i.fencei) begin
          if (fencei_ready_i) begin
            state_d = FL_REQ;
          end else begin
            state_d = FL_WAIT_READY;
          end
        end
      end
      FL_WAIT_READY: begin
        if (fencei_ready_i) begin
          state_d = FL_REQ;
        end
      end
      FL_REQ: begin
        // Req is held until the ack arrives together with it
        if (fencei_flush_ack_i) begin
          state_d = FL_DONE;
        end
      end
      FL_DONE: begin
        // The arbiter retires the fence.i in this cycle
        state_d = FL_IDLE;
      end
      default: begin
        state_d = FL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Req is a decode of the registered state and so rises one cycle after
  // the fence.i is seen with the write buffer empty
  assign fencei_flush_req_o = (state_q == FL_REQ);

  always_comb begin
    fencei_status_o = '0;
    unique case (state_q)
      // Busy already in the first cycle so the fence.i is not retired early
      FL_IDLE:       fencei_status_o.busy = insn_class_i.fencei;
      FL_WAIT_READY: fencei_status_o.busy = 1'b1;
      FL_REQ:        fencei_status_o.busy = 1'b1;
      FL_DONE:       fencei_status_o.done = 1'b1;
      default:       fencei_status_o = '0;
    endcase
  end

  //////////////////////////////
  // Handshake checks
  //////////////////////////////

  // The flush may only be requested while the write buffer stays empty
  a_req_needs_ready :
    assert property (@(posedge clk) disable iff (!rst_n)
                     fencei_flush_req_o |-> fencei_ready_i)
      else $error("fence.i flush req high while write buffer not empty");

  // Req is never withdrawn without an ack in the cycle before
  a_req_fall_after_ack :
    assert property (@(posedge clk) disable iff (!rst_n)
                     $fell(fencei_flush_req_o) |-> $past(fencei_flush_ack_i))
      else $error("fence.i flush req dropped without ack");

  // A completed handshake does not leave req standing
  a_req_clear_after_ack :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (fencei_flush_req_o && fencei_flush_ack_i) |=> !fencei_flush_req_o)
      else $error("fence.i flush req not cleared after req and ack");

endmodule

// ==== source/wb_insn_check.sv ====
// Writeback instruction checker
// Classifies the instruction in writeback and applies the privilege rules
// for mret and WFI. Purely combinational

`timescale 1ns/100ps

module wb_insn_check import wb_ctrl_pkg::*; (
  input  wb_instr_t   wb_instr_i,
  input  priv_lvl_e   priv_lvl_i,
  input  logic        mstatus_tw_i,
  output insn_class_t insn_class_o
);

  logic user_mode;

  // Only user and machine mode exist, so anything not M is treated as U
  assign user_mode = (priv_lvl_i != PRIV_M);

  always_comb begin
    insn_class_o = '0;
    insn_class_o.verdict = CLS_RETIRE;

    unique case (wb_instr_i.opcode)
      OP_MRET: begin
        // mret is a machine mode instruction
        // From user mode it traps as illegal
        if (user_mode) begin
          insn_class_o.verdict = CLS_ILLEGAL;
        end else begin
          insn_class_o.verdict = CLS_MRET;
        end
      end
      OP_WFI: begin
        // With mstatus.tw set, a WFI from user mode is illegal
        // Without tw it behaves like a nop here and simply retires
        if (user_mode && mstatus_tw_i) begin
          insn_class_o.verdict = CLS_ILLEGAL;
        end else begin
          insn_class_o.verdict = CLS_RETIRE;
        end
      end
      OP_LSU: begin
        insn_class_o.lsu = wb_instr_i.valid;
      end
      OP_FENCEI: begin
        insn_class_o.fencei = wb_instr_i.valid;
      end
      OP_CSR, OP_OTHER: begin
        // CSR accesses have their own checks upstream and retire here
        insn_class_o.verdict = CLS_RETIRE;
      end
      default: begin
        insn_class_o.verdict = CLS_RETIRE;
      end
    endcase
  end

endmodule

// ==== source/wb_ctrl_pkg.sv ====
// Writeback controller package
// Opcode, verdict and event encodings, the structs passed between the
// instruction checker, the fence.i flush controller and the event arbiter,
// and the trap cause constants

package wb_ctrl_pkg;

  //////////////////////////////
  // Widths and causes
  //////////////////////////////

  // Width of trap causes and interrupt ids
  parameter int unsigned CAUSE_W = 5;

  // Cause code reported for an illegal instruction exception
  localparam logic [CAUSE_W-1:0] EXC_ILLEGAL_INSN = 5'd2;

  //////////////////////////////
  // Instruction in writeback
  //////////////////////////////

  // Kind of instruction sitting in writeback, already decoded upstream
  typedef enum logic [2:0] {
    OP_OTHER  = 3'd0,
    OP_LSU    = 3'd1,
    OP_CSR    = 3'd2,
    OP_MRET   = 3'd3,
    OP_WFI    = 3'd4,
    OP_FENCEI = 3'd5
  } wb_opcode_e;

  // Privilege levels with their RISC-V encodings
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  typedef struct packed {
    logic       valid;
    wb_opcode_e opcode;
  } wb_instr_t;

  //////////////////////////////
  // Results of the side-by-side parts
  //////////////////////////////

  // What the instruction checker decided for the writeback instruction
  typedef enum logic [1:0] {
    CLS_RETIRE  = 2'd0,
    CLS_MRET    = 2'd1,
    CLS_ILLEGAL = 2'd2
  } verdict_e;

  typedef struct packed {
    verdict_e verdict;
    logic     lsu;
    logic     fencei;
  } insn_class_t;

  // Busy covers the whole flush, done is the single cycle after the ack
  typedef struct packed {
    logic busy;
    logic done;
  } fencei_status_t;

  //////////////////////////////
  // Reported events
  //////////////////////////////

  typedef enum logic [2:0] {
    EV_RETIRE    = 3'd0,
    EV_EXCEPTION = 3'd1,
    EV_INTERRUPT = 3'd2,
    EV_MRET      = 3'd3,
    EV_FENCEI    = 3'd4
  } event_kind_e;

  typedef struct packed {
    logic               valid;
    event_kind_e        kind;
    logic [CAUSE_W-1:0] cause;
  } wb_event_t;

endpackage
